// File: rtl/mem_pkg.sv
package mem_pkg;

    // load/store access type
    // the _U variants are zero-extended on a load and act like their signed twins on a store
    typedef enum logic [2:0]
    {
        L_S_BYTE   = 3'd0,      // 8 bit, sign extended
        L_S_HALF   = 3'd1,      // 16 bit, sign extended
        L_S_WORD   = 3'd2,      // full 32 bit
        L_S_BYTE_U = 3'd3,      // 8 bit, zero extended
        L_S_HALF_U = 3'd4       // 16 bit, zero extended
    } l_s_sel;

    // data value or processor byte address
    typedef logic [31:0] data_val;

    // one data word, seen either whole or as four byte lanes
    // lane 0 is the least significant byte, so lane n sits at address + n
    typedef union packed
    {
        data_val         word;  // plain value
        logic [3:0][7:0] lanes; // little endian byte lanes
    } data_word_u;

    // processor to cache request
    // held stable by the processor while its req is high
    typedef struct packed
    {
        data_val addr;          // byte address of lane 0
        logic    wr_en;         // 1 = store, 0 = load
        l_s_sel  kind;          // access size and extension
        data_val wdata;         // store data, low lanes used for narrow stores
    } mem_req_t;

    // cache to backing store request, always one byte
    typedef struct packed
    {
        data_val    addr;       // byte address, wrapped by the store
        logic       wr_en;      // 1 = write back, 0 = fill read
        logic [7:0] wdata;      // victim byte on a write back
    } bs_req_t;

endpackage

// File: rtl/load_extend.sv
`timescale 1ns/1ps

module load_extend
(
    input  mem_pkg::data_word_u i_bytes, // bytes collected by the cache
    input  mem_pkg::l_s_sel     i_kind,  // access type of the load
    output mem_pkg::data_val    o_val    // extended load result
);

    // purely combinational, so the result follows the byte buffer directly
    always_comb
    begin
        case (i_kind)
            mem_pkg::L_S_BYTE:
            begin
                o_val = {{24{i_bytes.lanes[0][7]}}, i_bytes.lanes[0]};       // sign from bit 7
            end
            mem_pkg::L_S_HALF:
            begin
                o_val = {{16{i_bytes.lanes[1][7]}}, i_bytes.word[15:0]};     // sign from bit 15
            end
            mem_pkg::L_S_WORD:
            begin
                o_val = i_bytes.word;                                        // all four lanes
            end
            mem_pkg::L_S_BYTE_U:
            begin
                o_val = {24'h000000, i_bytes.lanes[0]};                      // zero fill
            end
            mem_pkg::L_S_HALF_U:
            begin
                o_val = {16'h0000, i_bytes.word[15:0]};                      // zero fill
            end
            default:
            begin
                o_val = '0;                                                  // undefined kind
            end
        endcase
    end

endmodule

// File: rtl/byte_cache.sv
`timescale 1ns/1ps

module byte_cache #(
    parameter int ADDR_WIDTH = 12,      // backing store address bits
    parameter int SET_WIDTH  = 3        // cache index bits
) (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_req,      // processor request, four phase
    input  mem_pkg::mem_req_t   i_cmd,      // stable while i_req high
    output logic                o_ack,      // access complete
    output mem_pkg::data_word_u o_bytes,    // collected load bytes
    output mem_pkg::l_s_sel     o_kind,     // kind of the latched access
    output logic                o_bs_req,   // backing store request, four phase
    output mem_pkg::bs_req_t    o_bs_cmd,   // backing store command
    input  logic                i_bs_ack,   // backing store ack
    input  logic [7:0]          i_bs_rdata  // fill byte, valid with ack
);

    localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH;
    localparam int SETS      = 2 ** SET_WIDTH;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB,
        ST_FILL,
        ST_NEXT,
        ST_RESP
    } state_t;

    state_t state;

    // line arrays, one byte per line
    logic [SETS-1:0]      valid_q;              // cleared on reset
    logic [SETS-1:0]      dirty_q;
    logic [TAG_WIDTH-1:0] tag_mem  [SETS];
    logic [7:0]           data_mem [SETS];

    mem_pkg::mem_req_t   cmd_q;                 // latched request
    mem_pkg::data_word_u wdata_u;               // store data by lanes
    mem_pkg::data_word_u rbuf;                  // load bytes by lanes
    logic [1:0]          byte_idx;              // current byte offset
    logic [2:0]          byte_cnt;              // 1, 2 or 4
    logic                bs_phase;              // 1 while waiting for ack release

    mem_pkg::data_val     cur_addr;             // address of current byte
    logic [SET_WIDTH-1:0] cur_idx;
    logic [TAG_WIDTH-1:0] cur_tag;
    mem_pkg::data_val     victim_addr;          // address of the line being evicted
    logic                 line_hit;
    logic                 line_dirty;
    logic                 lookup_done;          // byte finished in lookup
    logic                 last_byte;
    logic                 step;                 // advance to next byte or respond
    logic                 in_xfer;              // a backing store handshake is running
    logic                 bs_start;
    logic                 bs_fire;              // ack seen while req high
    logic                 bs_done;              // ack dropped after release
    logic                 arr_we;

    function automatic logic [2:0] kind_bytes(input mem_pkg::l_s_sel kind);
        case (kind)
            mem_pkg::L_S_HALF, mem_pkg::L_S_HALF_U: kind_bytes = 3'd2;
            mem_pkg::L_S_WORD:                      kind_bytes = 3'd4;
            default:                                kind_bytes = 3'd1;
        endcase
    endfunction

    assign wdata_u.word = cmd_q.wdata;
    assign cur_addr     = cmd_q.addr + {30'd0, byte_idx};                    // bytes at consecutive addresses
    assign cur_idx      = cur_addr[SET_WIDTH-1:0];
    assign cur_tag      = cur_addr[ADDR_WIDTH-1:SET_WIDTH];
    assign victim_addr  = mem_pkg::data_val'({tag_mem[cur_idx], cur_idx});

    assign line_hit    = valid_q[cur_idx] && (tag_mem[cur_idx] == cur_tag);
    assign line_dirty  = valid_q[cur_idx] && dirty_q[cur_idx];
    assign lookup_done = line_hit || (cmd_q.wr_en && !line_dirty);           // store miss allocates, no fill
    assign last_byte   = ({1'b0, byte_idx} == (byte_cnt - 3'd1));
    assign step        = ((state == ST_LOOKUP) && lookup_done) || (state == ST_NEXT);

    assign in_xfer  = (state == ST_WB) || (state == ST_FILL);
    assign bs_start = in_xfer && !bs_phase && !o_bs_req && !i_bs_ack;      // never raise over a stale ack
    assign bs_fire  = in_xfer && o_bs_req && i_bs_ack;
    assign bs_done  = in_xfer && bs_phase && !i_bs_ack;

    // line write: store byte in lookup, or fill byte when the store acks
    assign arr_we = ((state == ST_LOOKUP) && cmd_q.wr_en && lookup_done)
                 || ((state == ST_FILL) && bs_fire);

    assign o_bytes = rbuf;
    assign o_kind  = cmd_q.kind;

    // sequencer and line state bits
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state    <= ST_IDLE;
            byte_idx <= '0;
            byte_cnt <= 3'd1;
            o_ack    <= 1'b0;
            o_bs_req <= 1'b0;
            bs_phase <= 1'b0;
            valid_q  <= '0;
            dirty_q  <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (i_req)
                    begin
                        byte_idx <= '0;
                        byte_cnt <= kind_bytes(i_cmd.kind);
                        state    <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP:
                begin
                    if (lookup_done && cmd_q.wr_en)
                    begin
                        valid_q[cur_idx] <= 1'b1;                           // hit or fresh allocation
                        dirty_q[cur_idx] <= 1'b1;
                    end
                    else if (!lookup_done)
                    begin
                        state <= line_dirty ? ST_WB : ST_FILL;              // victim goes out first
                    end
                end
                ST_WB:
                begin
                    if (bs_done)
                    begin
                        dirty_q[cur_idx] <= 1'b0;                           // line now clean, look again
                        state            <= ST_LOOKUP;
                    end
                end
                ST_FILL:
                begin
                    if (bs_fire)
                    begin
                        valid_q[cur_idx] <= 1'b1;
                        dirty_q[cur_idx] <= 1'b0;
                    end
                    if (bs_done)
                        state <= ST_NEXT;
                end
                ST_RESP:
                begin
                    if (!i_req)
                    begin
                        o_ack <= 1'b0;                                      // release seen
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= state;                                         // ST_NEXT handled by step
                end
            endcase

            if (step)
            begin
                if (last_byte)
                begin
                    o_ack <= 1'b1;
                    state <= ST_RESP;
                end
                else
                begin
                    byte_idx <= byte_idx + 2'd1;
                    state    <= ST_LOOKUP;
                end
            end

            // shared four phase handshake towards the backing store
            if (bs_start)
                o_bs_req <= 1'b1;
            if (bs_fire)
            begin
                o_bs_req <= 1'b0;
                bs_phase <= 1'b1;
            end
            if (bs_done)
                bs_phase <= 1'b0;
        end
    end

    // payload: command, line contents, load buffer, store command
    always_ff @(posedge i_clk)
    begin
        if ((state == ST_IDLE) && i_req)
            cmd_q <= i_cmd;

        if (arr_we)
        begin
            data_mem[cur_idx] <= (state == ST_FILL) ? i_bs_rdata : wdata_u.lanes[byte_idx];
            tag_mem[cur_idx]  <= cur_tag;
        end

        if ((state == ST_LOOKUP) && line_hit && !cmd_q.wr_en)
            rbuf.lanes[byte_idx] <= data_mem[cur_idx];                      // hit read
        if ((state == ST_FILL) && bs_fire)
            rbuf.lanes[byte_idx] <= i_bs_rdata;                             // fill byte straight in

        if ((state == ST_LOOKUP) && !lookup_done)
        begin
            if (line_dirty)
                o_bs_cmd <= '{addr: victim_addr, wr_en: 1'b1, wdata: data_mem[cur_idx]};
            else
                o_bs_cmd <= '{addr: mem_pkg::data_val'(cur_addr[ADDR_WIDTH-1:0]),
                              wr_en: 1'b0, wdata: 8'h00};
        end
    end

endmodule

// File: rtl/backing_store.sv
`timescale 1ns/1ps

module backing_store #(
    parameter int ADDR_WIDTH = 12,          // array address bits
    parameter int BS_LATENCY = 2            // cycles from req seen to ack
) (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_req,          // four phase request
    input  mem_pkg::bs_req_t i_cmd,          // byte command
    output logic             o_ack,          // ack, held until req drops
    output logic [7:0]       o_rdata         // read byte, valid with ack
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int CNT_W = (BS_LATENCY < 2) ? 1 : $clog2(BS_LATENCY + 1);

    logic [7:0]            mem [DEPTH];      // byte array
    logic [CNT_W-1:0]      lat_cnt;          // cycles since req seen
    logic [ADDR_WIDTH-1:0] addr;             // wrapped address
    logic                  fire;             // ack rises this edge

    // simulation start state, no image loaded
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = 8'h00;
    end

    assign addr = i_cmd.addr[ADDR_WIDTH-1:0];                                // modulo array size
    assign fire = i_req && !o_ack && (lat_cnt == CNT_W'(BS_LATENCY - 1));

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            lat_cnt <= '0;
            o_ack   <= 1'b0;
        end
        else
        begin
            if (fire)
            begin
                o_ack   <= 1'b1;
                lat_cnt <= '0;
            end
            else if (i_req && !o_ack)
                lat_cnt <= lat_cnt + 1'b1;                                  // still waiting
            else if (o_ack && !i_req)
                o_ack <= 1'b0;                                              // release
        end
    end

    // array access at the ack edge
    always_ff @(posedge i_clk)
    begin
        if (fire && i_cmd.wr_en)
            mem[addr] <= i_cmd.wdata;
        if (fire && !i_cmd.wr_en)
            o_rdata <= mem[addr];
    end

endmodule

// File: rtl/data_mem_top.sv
`timescale 1ns/1ps

module data_mem_top #(
    parameter int ADDR_WIDTH = 12,      // backing store size, 4 KiB
    parameter int SET_WIDTH  = 3,       // 8 cache lines
    parameter int BS_LATENCY = 2        // backing store delay
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_req,      // processor request
    input  mem_pkg::mem_req_t i_cmd,      // processor command
    output logic              o_ack,      // access done
    output mem_pkg::data_val  o_rdata     // load result, valid with o_ack
);

    mem_pkg::data_word_u cache_bytes;     // raw load bytes
    mem_pkg::l_s_sel     cache_kind;
    logic                bs_req;
    mem_pkg::bs_req_t    bs_cmd;
    logic                bs_ack;
    logic [7:0]          bs_rdata;

    byte_cache #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SET_WIDTH  (SET_WIDTH)
    ) u_cache (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_req      (i_req),
        .i_cmd      (i_cmd),
        .o_ack      (o_ack),
        .o_bytes    (cache_bytes),
        .o_kind     (cache_kind),
        .o_bs_req   (bs_req),
        .o_bs_cmd   (bs_cmd),
        .i_bs_ack   (bs_ack),
        .i_bs_rdata (bs_rdata)
    );

    // sign or zero extension, no added latency
    load_extend u_extend (
        .i_bytes (cache_bytes),
        .i_kind  (cache_kind),
        .o_val   (o_rdata)
    );

    backing_store #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BS_LATENCY (BS_LATENCY)
    ) u_store (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (bs_req),
        .i_cmd    (bs_cmd),
        .o_ack    (bs_ack),
        .o_rdata  (bs_rdata)
    );

endmodule

// File: verification/data_mem_chk.sv
`timescale 1ns/1ps

module data_mem_chk
(
    input logic              i_clk,
    input logic              i_arst_n,
    input logic              i_req,      // processor request
    input mem_pkg::mem_req_t i_cmd,      // processor command
    input logic              i_ack,      // cache ack towards processor
    input logic              i_bs_req,   // cache request towards backing store
    input logic              i_bs_ack    // backing store ack
);

    // both outgoing handshake lines stay quiet while reset is applied
    reset_quiet: assert property (@(posedge i_clk) !i_arst_n |-> !i_ack && !i_bs_req)
        else $error("o_ack or o_bs_req high during reset");

    cmd_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_req && $past(i_req) |-> $stable(i_cmd))                 // held for the whole req phase
        else $error("i_cmd changed while i_req high");

    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_ack) |-> $past(i_req))                            // no ack without a request
        else $error("o_ack rose without a preceding i_req");

    bs_req_after_release: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_bs_req) |-> !$past(i_bs_ack))                     // old ack gone at the raising edge
        else $error("o_bs_req rose while i_bs_ack high");

endmodule

bind byte_cache data_mem_chk u_chk
(
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_cmd    (i_cmd),
    .i_ack    (o_ack),
    .i_bs_req (o_bs_req),
    .i_bs_ack (i_bs_ack)
);

// File: verification/data_mem_tb.sv
`timescale 1ns/1ps

module data_mem_tb;

    localparam int    TIMEOUT_CYCLES = 200;                      // per wait loop
    localparam int    MAX_LINES      = 1000;                     // guard on the file loop
    localparam string GOLDEN_FILE    = "verification/data_mem_golden.txt";

    logic              i_clk;
    logic              i_arst_n;
    logic              i_req;
    mem_pkg::mem_req_t i_cmd;
    logic              o_ack;
    mem_pkg::data_val  o_rdata;

    int    n_access;                                             // accesses run
    int    n_mismatch;                                           // wrong load values
    int    n_timeout;                                            // waits that ran out
    int    n_handshake;                                          // early ack drops
    int    n_other;                                              // file problems
    int    fd;
    int    n_lines;
    int    fields;
    logic  ok;
    logic  stop_run;                                             // set after a timeout
    string line;
    logic [31:0] kind_v;
    logic [31:0] wr_v;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] exp_v;

    data_mem_top #(
        .ADDR_WIDTH (12),
        .SET_WIDTH  (3),
        .BS_LATENCY (2)
    ) i_dut (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_req),
        .i_cmd    (i_cmd),
        .o_ack    (o_ack),
        .o_rdata  (o_rdata)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;                               // 4 ns period
    end

    // wait until o_ack reaches the given level, sampled 1 ns after each edge
    task automatic wait_ack_level(input logic level, output logic done);
        int cycles;
        cycles = 0;
        while (o_ack !== level && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            #1;
            cycles++;
        end
        done = (o_ack === level);
        if (!done)
        begin
            n_timeout++;
            if (level)
                $display("no acknowledge from memory within timeout");
            else
                $display("acknowledge from memory did not drop within timeout after i_req fell");
        end
    endtask

    // one four phase access with the load value checked while o_ack is high
    task automatic run_access(input logic [31:0] kind, input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] expected,
                              output logic done);
        i_cmd = '{addr: addr, wr_en: wr, kind: mem_pkg::l_s_sel'(kind[2:0]), wdata: wdata};
        i_req = 1'b1;
        n_access++;
        wait_ack_level(1'b1, done);
        if (done && !wr && o_rdata !== expected)
        begin
            n_mismatch++;
            $display("Mismatch o_rdata: addr %08h kind %0h expected %08h got %08h",
                     addr, kind, expected, o_rdata);
        end
        if (done)
        begin
            @(posedge i_clk);                                    // request held one more cycle
            #1;
            if (o_ack !== 1'b1)
            begin
                n_handshake++;
                $display("acknowledge from memory dropped while i_req was still high");
            end
        end
        i_req = 1'b0;                                            // release
        if (done)
            wait_ack_level(1'b0, done);
    endtask

    // random gap of 0 to 3 cycles between accesses
    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap)
        begin
            @(posedge i_clk);
            #1;
        end
    endtask

    initial
    begin
        void'($urandom(32'h20962c95));
        n_access    = 0;
        n_mismatch  = 0;
        n_timeout   = 0;
        n_handshake = 0;
        n_other     = 0;
        n_lines     = 0;
        stop_run    = 1'b0;
        i_arst_n    = 1'b0;
        i_req       = 1'b0;
        i_cmd       = '0;
        repeat (5) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;
        @(posedge i_clk);
        #1;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            n_other++;
            $display("cannot open golden file %s", GOLDEN_FILE);
        end
        else
        begin
            while (!$feof(fd) && !stop_run && n_lines < MAX_LINES)
            begin
                line = "";
                void'($fgets(line, fd));
                n_lines++;
                if (line.len() > 0 && line.getc(0) != "#")   // skip column notes
                begin
                    fields = $sscanf(line, "%h %h %h %h %h", kind_v, wr_v, addr_v, wdata_v, exp_v);
                    if (fields == 5)
                    begin
                        run_access(kind_v, wr_v[0], addr_v, wdata_v, exp_v, ok);
                        if (!ok)
                            stop_run = 1'b1;                     // DUT is stuck so stop here
                        else
                            idle_gap();
                    end
                    else if (fields > 0)
                    begin
                        n_other++;
                        $display("malformed line %0d in golden file", n_lines);
                    end
                end
            end
            $fclose(fd);
        end
        if (n_access == 0)
        begin
            n_other++;
            $display("no accesses were read from the golden file");
        end

        $display("accesses %0d, mismatches %0d, timeouts %0d, handshake errors %0d, other errors %0d",
                 n_access, n_mismatch, n_timeout, n_handshake, n_other);
        if (n_mismatch == 0 && n_timeout == 0 && n_handshake == 0 && n_other == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: verification/data_mem_golden.txt
# kind (0 byte, 1 half, 2 word, 3 byte_u, 4 half_u)  wr  addr  wdata  expected, all hex
# expected is compared on loads only, stores carry 00000000 there
0 1 010 00000085 00000000
0 1 011 0000007F 00000000
0 0 010 00000000 FFFFFF85
3 0 010 00000000 00000085
0 0 011 00000000 0000007F
3 0 011 00000000 0000007F
1 1 020 00009A3C 00000000
1 0 020 00000000 FFFF9A3C
4 0 020 00000000 00009A3C
2 1 041 11223344 00000000
0 0 041 00000000 00000044
0 0 042 00000000 00000033
0 0 043 00000000 00000022
0 0 044 00000000 00000011
2 0 041 00000000 11223344
0 1 042 000000E7 00000000
2 0 041 00000000 1122E744
0 1 105 000000A5 00000000
0 1 205 0000005A 00000000
3 0 105 00000000 000000A5
0 0 205 00000000 0000005A
2 1 300 DEADBEEF 00000000
2 1 700 CAFEF00D 00000000
2 0 300 00000000 DEADBEEF
2 0 700 00000000 CAFEF00D
0 0 010 00000000 FFFFFF85
1 1 0FF 0000BEEF 00000000
1 0 0FF 00000000 FFFFBEEF
2 0 800 00000000 00000000
3 0 ABC 00000000 00000000
4 0 FFE 00000000 00000000
1 0 900 00000000 00000000

// File: build.f
rtl/mem_pkg.sv
rtl/load_extend.sv
rtl/byte_cache.sv
rtl/backing_store.sv
rtl/data_mem_top.sv
verification/data_mem_chk.sv
verification/data_mem_tb.sv

// File: Bender.yml
package:
  name: data_mem

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/load_extend.sv
      - rtl/byte_cache.sv
      - rtl/backing_store.sv
      - rtl/data_mem_top.sv
  - target: simulation
    files:
      - verification/data_mem_chk.sv
      - verification/data_mem_tb.sv
